// File: verilog/keccak_pkg.sv
package keccak_pkg;

    // Output word geometry
    localparam int unsigned w            = 64;
    localparam int unsigned w_byte_size  = 8;
    localparam int unsigned w_bit_width  = 6;
    localparam int unsigned w_byte_width = 3;

    // Rate of each SHAKE variant in bits
    localparam int unsigned RATE_SHAKE128 = 1344;
    localparam int unsigned RATE_SHAKE256 = 1088;

    // Operation mode codes
    localparam logic [1:0] SHAKE128_MODE_VEC = 2'b00;
    localparam logic [1:0] SHAKE256_MODE_VEC = 2'b01;

    // Word count field wide enough for 21 words per block
    localparam int unsigned REM_WORDS_WIDTH = 6;

    // Remaining output length seen as a bit count or split into
    // words and bytes within a block
    typedef union packed {
        logic [31:0] bits;
        struct packed {
            logic [31-REM_WORDS_WIDTH-w_bit_width:0] upper;
            logic [REM_WORDS_WIDTH-1:0]              words;
            logic [w_byte_width-1:0]                 bytes;
            // Always zero since lengths are whole bytes
            logic [w_bit_width-w_byte_width-1:0]     sub_byte;
        } fields;
    } remaining_size_u;

endpackage

// File: verilog/countern.sv
`timescale 1ns/100ps

module countern #(
    parameter int WIDTH = 5
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             load_max,
    input  logic             en,
    input  logic [WIDTH-1:0] max_count,
    output logic             count_last
);

    logic [WIDTH-1:0] count;

    // Down counter where a load wins over a step
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (load_max) begin
            count <= max_count - 1'b1;
        end else if (en) begin
            count <= count - 1'b1;
        end
    end

    // Last count reached when the counter sits at zero
    assign count_last = (count == '0);

endmodule

// File: verilog/piso_buffer.sv
`timescale 1ns/100ps

module piso_buffer #(
    parameter int WIDTH = 64,
    parameter int DEPTH = 21
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   write_enable,
    input  logic                   shift_enable,
    input  logic [WIDTH*DEPTH-1:0] data_i,
    output logic [WIDTH-1:0]       data_o
);

    logic [WIDTH-1:0] buffer [DEPTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                buffer[i] <= '0;
            end
        end else if (write_enable) begin
            // Word k comes from bits 64k+63 down to 64k
            for (int i = 0; i < DEPTH; i++) begin
                buffer[i] <= data_i[i*WIDTH +: WIDTH];
            end
        end else if (shift_enable) begin
            for (int i = 0; i < DEPTH - 1; i++) begin
                buffer[i] <= buffer[i+1];
            end
            buffer[DEPTH-1] <= '0;
        end
    end

    // Head of the buffer is always the next word out
    assign data_o = buffer[0];

endmodule

// File: verilog/dump_datapath.sv
`timescale 1ns/100ps

module dump_datapath
    import keccak_pkg::*;
#(
    parameter int DEPTH = 21
) (
    input  logic                     clk,
    input  logic                     rst_n,

    // Block from the permutation and request info
    input  logic [RATE_SHAKE128-1:0] rate_output,
    input  remaining_size_u          remaining_size,
    input  logic [1:0]               operation_mode,

    // Strobes from the controller
    input  logic                     output_buffer_we,
    input  logic                     last_output_block,
    input  logic                     output_buffer_shift_en,
    input  logic                     output_counter_load,
    input  logic                     valid_bytes_enable,

    output logic                     last_word_from_block,
    output logic [w-1:0]             data_o
);

    logic [4:0]                 max_buffer_depth;
    logic [REM_WORDS_WIDTH-1:0] remaining_valid_words;
    logic [REM_WORDS_WIDTH-1:0] extra_valid_word;
    logic [w_byte_width-1:0]    remaining_valid_bytes;
    logic [w_byte_width-1:0]    valid_bytes_q;
    logic [w-1:0]               buffer_output;
    logic [w_byte_size-1:0]     zero_mask_sel;

    // Words left in the current block
    countern #(
        .WIDTH(5)
    ) output_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_max   (output_counter_load),
        .en         (output_buffer_shift_en),
        .max_count  (max_buffer_depth),
        .count_last (last_word_from_block)
    );

    piso_buffer #(
        .WIDTH(w),
        .DEPTH(DEPTH)
    ) output_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .write_enable (output_buffer_we),
        .shift_enable (output_buffer_shift_en),
        .data_i       (rate_output),
        .data_o       (buffer_output)
    );

    // Final block may end in a partial word
    assign remaining_valid_bytes = remaining_size.fields.bytes;
    assign extra_valid_word      = (remaining_valid_bytes != '0) ? 6'd1 : 6'd0;
    assign remaining_valid_words = remaining_size.fields.words + extra_valid_word;

    always_comb begin
        if (last_output_block) begin
            max_buffer_depth = remaining_valid_words[4:0];
        end else if (operation_mode == SHAKE256_MODE_VEC) begin
            max_buffer_depth = 5'd17;
        end else begin
            max_buffer_depth = 5'd21;
        end
    end

    // Byte count only matters for the final block
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_bytes_q <= '0;
        end else if (valid_bytes_enable) begin
            valid_bytes_q <= last_output_block ? remaining_valid_bytes : '0;
        end
    end

    // Keep the top n bytes of the last word and zero the rest
    assign zero_mask_sel = (last_word_from_block && valid_bytes_q != '0) ?
                           (8'hFF >> valid_bytes_q) : '0;

    always_comb begin
        for (int i = 0; i < w_byte_size; i++) begin
            data_o[i*8 +: 8] = zero_mask_sel[i] ? 8'h00 : buffer_output[i*8 +: 8];
        end
    end

endmodule

// File: verilog/dump_control.sv
`timescale 1ns/100ps

module dump_control
    import keccak_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,

    // Request and block source
    input  logic            start,
    input  logic [31:0]     output_size,
    input  logic [1:0]      operation_mode,
    input  logic            block_valid,
    output logic            block_request,

    // Stream status
    output logic            data_valid,
    output logic            done,
    output logic            busy,

    // Datapath control
    input  logic            last_word_from_block,
    output logic            output_buffer_we,
    output logic            output_buffer_shift_en,
    output logic            output_counter_load,
    output logic            valid_bytes_enable,
    output logic            last_output_block,
    output remaining_size_u remaining_size,
    output logic [1:0]      mode_q
);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_REQUEST = 2'd1;
    localparam logic [1:0] ST_STREAM  = 2'd2;
    localparam logic [1:0] ST_FINISH  = 2'd3;

    logic [1:0]  state;
    logic [1:0]  state_next;
    logic [31:0] rate_bits;
    logic        block_load;
    logic        block_end;

    assign rate_bits = (mode_q == SHAKE256_MODE_VEC) ? 32'(RATE_SHAKE256) : 32'(RATE_SHAKE128);

    // Block is taken in the same cycle it is offered
    assign block_load = (state == ST_REQUEST) && block_valid;
    assign block_end  = (state == ST_STREAM) && last_word_from_block;

    // Final block once the rest fits in one rate
    assign last_output_block = (remaining_size.bits <= rate_bits);

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    state_next = ST_REQUEST;
                end
            end
            ST_REQUEST: begin
                if (block_valid) begin
                    state_next = ST_STREAM;
                end
            end
            ST_STREAM: begin
                if (last_word_from_block) begin
                    state_next = last_output_block ? ST_FINISH : ST_REQUEST;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Remaining bits shrink by one rate per full block
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode_q              <= SHAKE128_MODE_VEC;
            remaining_size.bits <= '0;
        end else if (state == ST_IDLE && start) begin
            mode_q              <= operation_mode;
            remaining_size.bits <= output_size;
        end else if (block_end && !last_output_block) begin
            remaining_size.bits <= remaining_size.bits - rate_bits;
        end
    end

    assign block_request          = (state == ST_REQUEST);
    assign data_valid             = (state == ST_STREAM);
    assign output_buffer_shift_en = (state == ST_STREAM);
    assign done                   = (state == ST_FINISH);
    assign busy                   = (state != ST_IDLE);

    // Buffer, word counter and byte count all load together
    assign output_buffer_we    = block_load;
    assign output_counter_load = block_load;
    assign valid_bytes_enable  = block_load;

endmodule

// File: verilog/dump_unit.sv
`timescale 1ns/100ps

module dump_unit
    import keccak_pkg::*;
#(
    parameter int DEPTH = 21
) (
    input  logic                     clk,
    input  logic                     rst_n,

    // Squeeze request
    input  logic                     start,
    input  logic [31:0]              output_size,
    input  logic [1:0]               operation_mode,

    // Rate blocks from the permutation
    input  logic [RATE_SHAKE128-1:0] rate_block,
    input  logic                     block_valid,
    output logic                     block_request,

    // Output stream
    output logic [w-1:0]             data_o,
    output logic                     data_valid,
    output logic                     done,
    output logic                     busy
);

    logic            output_buffer_we;
    logic            output_buffer_shift_en;
    logic            output_counter_load;
    logic            valid_bytes_enable;
    logic            last_output_block;
    logic            last_word_from_block;
    remaining_size_u remaining_size;
    logic [1:0]      mode_q;

    dump_control control (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .start                  (start),
        .output_size            (output_size),
        .operation_mode         (operation_mode),
        .block_valid            (block_valid),
        .block_request          (block_request),
        .data_valid             (data_valid),
        .done                   (done),
        .busy                   (busy),
        .last_word_from_block   (last_word_from_block),
        .output_buffer_we       (output_buffer_we),
        .output_buffer_shift_en (output_buffer_shift_en),
        .output_counter_load    (output_counter_load),
        .valid_bytes_enable     (valid_bytes_enable),
        .last_output_block      (last_output_block),
        .remaining_size         (remaining_size),
        .mode_q                 (mode_q)
    );

    // Mode comes from the latched copy rather than the raw input
    dump_datapath #(
        .DEPTH(DEPTH)
    ) datapath (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .rate_output            (rate_block),
        .remaining_size         (remaining_size),
        .operation_mode         (mode_q),
        .output_buffer_we       (output_buffer_we),
        .last_output_block      (last_output_block),
        .output_buffer_shift_en (output_buffer_shift_en),
        .output_counter_load    (output_counter_load),
        .valid_bytes_enable     (valid_bytes_enable),
        .last_word_from_block   (last_word_from_block),
        .data_o                 (data_o)
    );

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Free running with 50 ns high and 50 ns low
    always #(PERIOD / 2) clk = ~clk;

endmodule

// File: tb/dump_unit_sva.sv
`timescale 1ns/100ps

module dump_unit_sva (
    input logic clk,
    input logic rst_n,
    input logic block_valid,
    input logic block_request,
    input logic data_valid,
    input logic done,
    input logic busy
);

    // Words only appear inside a request
    valid_within_busy: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(data_valid) |-> busy
    ) else $error("data_valid rose while busy was low");

    // Request drops once a block has been taken
    request_drops_after_block: assert property (
        @(posedge clk) disable iff (!rst_n) (block_valid && block_request) |=> !block_request
    ) else $error("block_request still high in the cycle after block_valid");

    done_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) done |=> !done
    ) else $error("done held high for more than one cycle");

endmodule

bind dump_unit dump_unit_sva strobe_checks (
    .clk           (clk),
    .rst_n         (rst_n),
    .block_valid   (block_valid),
    .block_request (block_request),
    .data_valid    (data_valid),
    .done          (done),
    .busy          (busy)
);

// File: tb/tb_dump_unit.sv
`timescale 1ns/100ps

module tb_dump_unit
    import keccak_pkg::*;
();

    logic                     clk;
    logic                     rst_n;
    logic                     start;
    logic [31:0]              output_size;
    logic [1:0]               operation_mode;
    logic [RATE_SHAKE128-1:0] rate_block;
    logic                     block_valid;
    logic                     block_request;
    logic [w-1:0]             data_o;
    logic                     data_valid;
    logic                     done;
    logic                     busy;

    // Reference model of the request in flight
    logic [w-1:0] expected_q[$];
    int           words_left;
    int           tail_bytes;
    int           rate_words;

    string        test_names[$];
    logic [1:0]   test_modes[$];
    int           test_sizes[$];
    int           test_aborts[$];

    int tests_run;
    int tests_failed;
    int words_checked;
    int error_total;
    int watchdog_cycles;

    tb_clock_gen clock_gen (
        .clk(clk)
    );

    dump_unit #(
        .DEPTH(21)
    ) uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .output_size    (output_size),
        .operation_mode (operation_mode),
        .rate_block     (rate_block),
        .block_valid    (block_valid),
        .block_request  (block_request),
        .data_o         (data_o),
        .data_valid     (data_valid),
        .done           (done),
        .busy           (busy)
    );

    // Keep the n most significant bytes and zero the rest
    function automatic logic [w-1:0] mask_final_word(input logic [w-1:0] word, input int n_bytes);
        logic [w-1:0] masked;
        masked = word;
        if (n_bytes != 0) begin
            for (int b = 0; b < 8 - n_bytes; b++) begin
                masked[b*8 +: 8] = 8'h00;
            end
        end
        return masked;
    endfunction

    function automatic logic [RATE_SHAKE128-1:0] random_block();
        logic [RATE_SHAKE128-1:0] block;
        for (int i = 0; i < RATE_SHAKE128 / 32; i++) begin
            block[i*32 +: 32] = $urandom;
        end
        return block;
    endfunction

    // Expand one block into the words still owed with word 0 from the low bits
    function automatic void queue_block_words(input logic [RATE_SHAKE128-1:0] block);
        int           count;
        logic [w-1:0] word;
        count = (words_left < rate_words) ? words_left : rate_words;
        for (int k = 0; k < count; k++) begin
            word = block[k*64 +: 64];
            if (words_left == 1) begin
                word = mask_final_word(word, tail_bytes);
            end
            expected_q.push_back(word);
            words_left--;
        end
    endfunction

    function automatic void add_test(input string name, input logic [1:0] mode,
                                     input int size, input int abort_after);
        test_names.push_back(name);
        test_modes.push_back(mode);
        test_sizes.push_back(size);
        test_aborts.push_back(abort_after);
    endfunction

    task automatic apply_reset(input int cycles);
        rst_n = 1'b0;
        start = 1'b0;
        block_valid = 1'b0;
        repeat (cycles) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // One squeeze request; abort_after > 0 resets the DUT after that many words
    task automatic run_request(input string name, input logic [1:0] mode, input int size,
                               input int abort_after);
        int           total_words;
        int           blocks_expected;
        int           limit;
        int           cycles;
        int           words_seen;
        int           errors;
        int           delay;
        int           blocks_served;
        int           last_word_cycle;
        bit           armed;
        bit           done_seen;
        bit           aborted;
        logic [w-1:0] exp_word;

        rate_words = (mode == SHAKE256_MODE_VEC) ? RATE_SHAKE256 / 64 : RATE_SHAKE128 / 64;
        total_words = (size + 63) / 64;
        words_left = total_words;
        tail_bytes = (size % 64) / 8;
        blocks_expected = (total_words + rate_words - 1) / rate_words;
        limit = 50 * total_words + 100;
        cycles = 0;
        words_seen = 0;
        errors = 0;
        delay = 0;
        blocks_served = 0;
        last_word_cycle = -2;
        armed = 1'b0;
        done_seen = 1'b0;
        aborted = 1'b0;
        expected_q.delete();

        @(negedge clk);
        start = 1'b1;
        output_size = size;
        operation_mode = mode;
        while (!done_seen && !aborted && cycles < limit) begin
            @(negedge clk);
            start = 1'b0;
            if (cycles == 0 && !block_request) begin
                $display("%s: block_request did not rise after start", name);
                errors++;
            end
            if (data_valid) begin
                if (expected_q.size() == 0) begin
                    $display("%s: extra word %h beyond the requested length", name, data_o);
                    errors++;
                end else begin
                    exp_word = expected_q.pop_front();
                    if (data_o !== exp_word) begin
                        $display("ERR %s word %0d: expected %h actual %h",
                                 name, words_seen, exp_word, data_o);
                        errors++;
                    end
                end
                words_seen++;
                last_word_cycle = cycles;
            end
            done_seen = done;
            if (done_seen && last_word_cycle != cycles - 1) begin
                $display("%s: done did not come in the cycle after the final word", name);
                errors++;
            end
            // Block source answers each request after a random delay
            if (abort_after > 0 && words_seen == abort_after) begin
                aborted = 1'b1;
            end else if (block_valid) begin
                block_valid = 1'b0;
            end else if (block_request) begin
                if (!armed) begin
                    delay = $urandom % 4;
                    armed = 1'b1;
                end
                if (delay == 0) begin
                    rate_block = random_block();
                    block_valid = 1'b1;
                    queue_block_words(rate_block);
                    blocks_served++;
                    armed = 1'b0;
                end else begin
                    delay--;
                end
            end
            cycles++;
        end

        if (aborted) begin
            expected_q.delete();
            apply_reset(16);
            @(negedge clk);
            if (block_request || data_valid || done || busy) begin
                $display("%s: outputs not idle after reset", name);
                errors++;
            end
        end else if (!done_seen) begin
            $display("%s: no done within %0d cycles", name, limit);
            errors++;
            apply_reset(16);
        end else begin
            if (expected_q.size() != 0) begin
                $display("%s: done came with %0d words missing", name, expected_q.size());
                errors++;
            end
            if (words_seen != total_words) begin
                $display("ERR %s word count: expected %0d actual %0d",
                         name, total_words, words_seen);
                errors++;
            end
            if (blocks_served != blocks_expected) begin
                $display("ERR %s block count: expected %0d actual %0d",
                         name, blocks_expected, blocks_served);
                errors++;
            end
            repeat (2) begin
                @(negedge clk);
                if (data_valid) begin
                    $display("%s: word streamed after done", name);
                    errors++;
                end
                if (busy) begin
                    $display("%s: busy still high after done", name);
                    errors++;
                end
            end
        end

        tests_run++;
        words_checked += words_seen;
        error_total += errors;
        if (errors == 0) begin
            $display("%s: ok, %0d words", name, words_seen);
        end else begin
            tests_failed++;
            $display("%s: %0d errors, %0d words", name, errors, words_seen);
        end
    endtask

    initial begin
        int         total_words;
        int         size;
        int         bytes;
        logic [1:0] mode;

        rst_n = 1'b0;
        start = 1'b0;
        output_size = '0;
        operation_mode = SHAKE128_MODE_VEC;
        rate_block = '0;
        block_valid = 1'b0;
        tests_run = 0;
        tests_failed = 0;
        words_checked = 0;
        error_total = 0;
        void'($urandom(32'hca201597));

        add_test("shake128_one_block", SHAKE128_MODE_VEC, RATE_SHAKE128, 0);
        for (int i = 0; i < 3; i++) begin
            size = 64 * int'($urandom % 50 + 18);
            add_test($sformatf("shake256_blocks_%0d", i), SHAKE256_MODE_VEC, size, 0);
        end
        // Lengths that end inside a word
        for (int i = 0; i < 4; i++) begin
            bytes = $urandom % 400 + 1;
            if (bytes % 8 == 0) begin
                bytes += 3;
            end
            mode = (i % 2 == 0) ? SHAKE128_MODE_VEC : SHAKE256_MODE_VEC;
            add_test($sformatf("partial_bytes_%0d", i), mode, 8 * bytes, 0);
        end
        for (int i = 0; i < 2; i++) begin
            size = 8 * int'($urandom % 7 + 1);
            mode = (i % 2 == 0) ? SHAKE256_MODE_VEC : SHAKE128_MODE_VEC;
            add_test($sformatf("sub_word_%0d", i), mode, size, 0);
        end
        add_test("reset_mid_stream", SHAKE128_MODE_VEC, 3 * RATE_SHAKE128 + 40,
                 int'($urandom % 36 + 5));
        add_test("after_reset", SHAKE256_MODE_VEC, 8 * int'($urandom % 300 + 150), 0);

        total_words = 0;
        foreach (test_sizes[i]) begin
            total_words += (test_sizes[i] + 63) / 64;
        end
        watchdog_cycles = 50 * total_words + 2000;

        apply_reset(16);
        foreach (test_names[i]) begin
            run_request(test_names[i], test_modes[i], test_sizes[i], test_aborts[i]);
        end

        $display("%0d tests, %0d failed, %0d words checked, %0d errors",
                 tests_run, tests_failed, words_checked, error_total);
        if (error_total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Bounds the whole run
    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles", watchdog_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: compile.f
verilog/keccak_pkg.sv
verilog/countern.sv
verilog/piso_buffer.sv
verilog/dump_datapath.sv
verilog/dump_control.sv
verilog/dump_unit.sv
tb/tb_clock_gen.sv
tb/dump_unit_sva.sv
tb/tb_dump_unit.sv

// File: run.sh
#!/usr/bin/env bash
# Build the dump_unit testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_dump_unit -f compile.f \
    -Mdir obj_dir -o tb_dump_unit

sim_output=$(./obj_dir/tb_dump_unit) || true
echo "$sim_output"

if echo "$sim_output" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
exit 1
